// File: logic/usb_xact_config.svh
`ifndef USB_XACT_CONFIG_SVH
`define USB_XACT_CONFIG_SVH

// Bus and field widths
`define USB_ADDR_W   7
`define USB_ENDP_W   4
`define USB_BYTE_W   8

// Endpoints with their own DATA0/DATA1 parity bit
`define USB_NUM_ENDP 4
// The only endpoint that takes bulk traffic
`define BULK_ENDP    1

// Cycles from usb_recv_i to the end-of-packet strobe
`define EOP_DELAY    6

// Token types, as delivered by the packet decoder
`define PID_OUT      2'b00
`define PID_SOF      2'b01
`define PID_IN       2'b10
`define PID_SETUP    2'b11

// Handshake types
`define HSK_ACK      2'b00
`define HSK_NAK      2'b10

// Data PIDs for the encoder
`define DATA0        2'b00
`define DATA1        2'b10

`endif

// File: logic/usb_xact_pkg.sv
`include "usb_xact_config.svh"

package usb_xact_pkg;

  // One byte of an AXI4-Stream style data stream
  // A zero-data packet is a single beat with tkeep low and tlast high
  typedef struct packed {
    logic                   tlast;
    logic                   tkeep;
    logic [`USB_BYTE_W-1:0] tdata;
  } beat_t;

  // Token as decoded from the wire
  typedef struct packed {
    logic [1:0]             ttype;
    logic [`USB_ADDR_W-1:0] addr;
    logic [`USB_ENDP_W-1:0] endp;
  } token_t;

  // Bulk request handed from the token stage to the transfer FSM
  typedef struct packed {
    logic                   is_in;
    logic [`USB_ENDP_W-1:0] endp;
  } bulk_req_t;

  // Reason the last token for this address was rejected
  typedef enum logic [2:0] {
    NONE = 3'd0,
    BLKI = 3'd1,
    BLKO = 3'd2,
    TOKN = 3'd3
  } err_code_e;

  // Bulk transfer FSM states
  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    DATI_TX  = 3'd1,
    DATI_ZDP = 3'd2,
    DATI_ACK = 3'd3,
    DATO_RX  = 3'd4,
    DATO_ERR = 3'd5,
    DATO_HSK = 3'd6,
    DONE     = 3'd7
  } bulk_state_e;

endpackage

// File: logic/token_decoder.sv
`timescale 1ns/1ns
`include "usb_xact_config.svh"

module token_decoder (
  input  logic                    clock,
  input  logic                    reset,
  input  logic [`USB_ADDR_W-1:0]  usb_addr_i,
  input  logic                    tok_recv_i,
  input  usb_xact_pkg::token_t    tok_i,
  input  logic                    req_ready_i,
  output logic                    req_valid_o,
  output usb_xact_pkg::bulk_req_t req_o,
  output usb_xact_pkg::err_code_e err_code_o
);

  localparam logic [`USB_ENDP_W-1:0] BULK_EP = `BULK_ENDP;

  logic                    req_valid_q;
  usb_xact_pkg::bulk_req_t req_q;
  usb_xact_pkg::err_code_e err_q;
  logic                    tok_hit;
  logic                    is_bulk_ep;

  // Our address, and nothing already waiting on the FSM
  assign tok_hit    = tok_recv_i && (tok_i.addr == usb_addr_i) && !req_valid_q;
  assign is_bulk_ep = tok_i.endp == BULK_EP;

  always_ff @(posedge clock) begin
    if (reset) begin
      req_valid_q <= 1'b0;
      err_q       <= usb_xact_pkg::NONE;
    end else begin
      // Request leaves once the FSM takes it
      if (req_valid_q && req_ready_i) begin
        req_valid_q <= 1'b0;
      end
      if (tok_hit) begin
        case (tok_i.ttype)
          `PID_IN, `PID_OUT: begin
            if (is_bulk_ep) begin
              req_valid_q <= 1'b1;
              err_q       <= usb_xact_pkg::NONE;
            end else if (tok_i.ttype == `PID_IN) begin
              err_q <= usb_xact_pkg::BLKI;
            end else begin
              err_q <= usb_xact_pkg::BLKO;
            end
          end
          // No control path, so SETUP is just an unsupported token
          `PID_SETUP: err_q <= usb_xact_pkg::TOKN;
          // SOF leaves everything as it was
          default: err_q <= err_q;
        endcase
      end
    end
  end

  // Request fields, only meaningful while req_valid_q is high
  always_ff @(posedge clock) begin
    if (tok_hit && is_bulk_ep) begin
      req_q.is_in <= tok_i.ttype == `PID_IN;
      req_q.endp  <= tok_i.endp;
    end
  end

  assign req_valid_o = req_valid_q;
  assign req_o       = req_q;
  assign err_code_o  = err_q;

endmodule

// File: logic/data_toggle.sv
`timescale 1ns/1ns
`include "usb_xact_config.svh"

module data_toggle (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [`USB_ENDP_W-1:0] endp_i,
  input  logic                   flip_i,
  output logic                   odd_o
);

  // Index width into the parity vector, at least one bit
  localparam int IDX_W = (`USB_NUM_ENDP > 1) ? $clog2(`USB_NUM_ENDP) : 1;

  // One bit per endpoint, low means DATA0 is next
  logic [`USB_NUM_ENDP-1:0] odd_q;
  logic [IDX_W-1:0]         idx;
  logic                     endp_ok;

  assign idx = endp_i[IDX_W-1:0];

  // Endpoints past the table have no parity bit
  assign endp_ok = int'(endp_i) < `USB_NUM_ENDP;

  always_ff @(posedge clock) begin
    if (reset) begin
      odd_q <= '0;
    end else if (flip_i && endp_ok) begin
      // Successful handshake moves that endpoint to the other PID
      odd_q[idx] <= ~odd_q[idx];
    end
  end

  // Unknown endpoints read as DATA0
  assign odd_o = endp_ok ? odd_q[idx] : 1'b0;

endmodule

// File: logic/axis_skid.sv
`timescale 1ns/1ns
`include "usb_xact_config.svh"

module axis_skid #(
  parameter type payload_t = logic [`USB_BYTE_W-1:0]
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     s_valid_i,
  input  payload_t s_data_i,
  output logic     s_ready_o,
  output logic     m_valid_o,
  output payload_t m_data_o,
  input  logic     m_ready_i
);

  // Output register plus one overflow entry
  logic     valid_q;
  logic     skid_valid_q;
  payload_t data_q;
  payload_t skid_q;
  logic     load_out;

  // Output register is free when empty or being drained
  assign load_out = m_ready_i || !valid_q;

  // Ready comes straight from a flop
  assign s_ready_o = !skid_valid_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q      <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (load_out) begin
      // Skid entry drains first so order is kept
      valid_q      <= skid_valid_q || s_valid_i;
      skid_valid_q <= 1'b0;
    end else if (s_valid_i && s_ready_o) begin
      // Output stalled, park the incoming beat
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (load_out) begin
      data_q <= skid_valid_q ? skid_q : s_data_i;
    end else if (s_valid_i && s_ready_o) begin
      skid_q <= s_data_i;
    end
  end

  assign m_valid_o = valid_q;
  assign m_data_o  = data_q;

endmodule

// File: logic/bulk_xfer_fsm.sv
`timescale 1ns/1ns
`include "usb_xact_config.svh"

module bulk_xfer_fsm (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    req_valid_i,
  input  usb_xact_pkg::bulk_req_t req_i,
  output logic                    req_ready_o,
  input  logic                    blk_in_ready_i,
  input  logic                    blk_out_ready_i,
  input  logic                    usb_recv_i,
  input  logic                    usb_sent_i,
  input  logic                    hsk_recv_i,
  input  logic [1:0]              hsk_type_i,
  input  logic                    hsk_sent_i,
  output logic                    hsk_send_o,
  output logic [1:0]              hsk_type_o,
  input  logic                    odd_i,
  output logic [`USB_ENDP_W-1:0]  endp_o,
  output logic                    flip_o,
  input  usb_xact_pkg::beat_t     blk_tx_i,
  input  logic                    blk_tx_valid_i,
  output logic                    blk_tx_ready_o,
  output usb_xact_pkg::beat_t     tx_o,
  output logic                    tx_valid_o,
  input  logic                    tx_ready_i,
  output logic [1:0]              usb_tuser_o,
  input  usb_xact_pkg::beat_t     usb_rx_i,
  input  logic                    usb_rx_valid_i,
  output logic                    usb_rx_ready_o,
  output usb_xact_pkg::beat_t     rx_o,
  output logic                    rx_valid_o,
  input  logic                    rx_ready_i
);

  localparam int EOP_W = $clog2(`EOP_DELAY + 1);

  // Empty packet sent when the bulk source has nothing
  localparam usb_xact_pkg::beat_t ZDP_BEAT = '{tlast: 1'b1, tkeep: 1'b0, tdata: '0};

  usb_xact_pkg::bulk_state_e state_q;
  logic [`USB_ENDP_W-1:0]    endp_q;
  logic [EOP_W-1:0]          eop_cnt_q;
  logic                      eop_pend_q;
  logic                      last_q;
  logic                      hsk_send_q;
  logic [1:0]                hsk_type_q;
  logic                      in_tx;
  logic                      in_zdp;
  logic                      out_rx;
  logic                      out_err;
  logic                      out_state;
  logic                      tx_move;
  logic                      rx_move;
  logic                      rx_end;
  logic                      eop_w;
  logic                      hsk_go;

  assign in_tx     = state_q == usb_xact_pkg::DATI_TX;
  assign in_zdp    = state_q == usb_xact_pkg::DATI_ZDP;
  assign out_rx    = state_q == usb_xact_pkg::DATO_RX;
  assign out_err   = state_q == usb_xact_pkg::DATO_ERR;
  assign out_state = out_rx || out_err;

  // IN data towards the encoder stops after the tlast beat
  assign tx_valid_o     = !last_q && (in_zdp || (in_tx && blk_tx_valid_i));
  assign tx_o           = in_tx ? blk_tx_i : ZDP_BEAT;
  assign blk_tx_ready_o = in_tx && !last_q && tx_ready_i;
  assign tx_move        = tx_valid_o && tx_ready_i;
  // Data PID follows the parity bit of the current endpoint
  assign usb_tuser_o    = odd_i ? `DATA1 : `DATA0;

  // OUT data goes to the sink and is swallowed in DATO_ERR
  assign rx_o           = usb_rx_i;
  assign rx_valid_o     = out_rx && !last_q && usb_rx_valid_i;
  assign usb_rx_ready_o = !last_q && (out_err || (out_rx && rx_ready_i));
  assign rx_move        = usb_rx_valid_i && usb_rx_ready_o;
  assign rx_end         = last_q || (rx_move && usb_rx_i.tlast);

  // End-of-packet strobe comes `EOP_DELAY cycles after usb_recv_i
  assign eop_w  = eop_cnt_q == EOP_W'(1);
  // Handshake goes out once the whole packet is in and EOP has passed
  assign hsk_go = out_state && rx_end && (eop_w || eop_pend_q);

  always_ff @(posedge clock) begin
    if (reset) begin
      eop_cnt_q <= '0;
    end else if (usb_recv_i) begin
      eop_cnt_q <= EOP_W'(`EOP_DELAY);
    end else if (eop_cnt_q != '0) begin
      eop_cnt_q <= eop_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q    <= usb_xact_pkg::IDLE;
      endp_q     <= '0;
      last_q     <= 1'b0;
      eop_pend_q <= 1'b0;
      hsk_send_q <= 1'b0;
    end else begin
      // Remember an EOP that beat the last data byte
      if (state_q == usb_xact_pkg::IDLE) begin
        eop_pend_q <= 1'b0;
      end else if (eop_w) begin
        eop_pend_q <= 1'b1;
      end
      case (state_q)
        usb_xact_pkg::IDLE: begin
          last_q <= 1'b0;
          if (req_valid_i) begin
            endp_q <= req_i.endp;
            if (req_i.is_in) begin
              state_q <= blk_in_ready_i ? usb_xact_pkg::DATI_TX : usb_xact_pkg::DATI_ZDP;
            end else begin
              state_q <= blk_out_ready_i ? usb_xact_pkg::DATO_RX : usb_xact_pkg::DATO_ERR;
            end
          end
        end
        usb_xact_pkg::DATI_TX, usb_xact_pkg::DATI_ZDP: begin
          if (tx_move && tx_o.tlast) begin
            last_q <= 1'b1;
          end
          // Encoder reports the packet is out on the wire
          if (usb_sent_i) begin
            state_q <= usb_xact_pkg::DATI_ACK;
          end
        end
        usb_xact_pkg::DATI_ACK: begin
          // Any host handshake ends it and only ACK flips parity
          if (hsk_recv_i) begin
            state_q <= usb_xact_pkg::DONE;
          end
        end
        usb_xact_pkg::DATO_RX, usb_xact_pkg::DATO_ERR: begin
          if (rx_move && usb_rx_i.tlast) begin
            last_q <= 1'b1;
          end
          if (hsk_go) begin
            hsk_send_q <= 1'b1;
            state_q    <= usb_xact_pkg::DATO_HSK;
          end
        end
        usb_xact_pkg::DATO_HSK: begin
          if (hsk_sent_i) begin
            hsk_send_q <= 1'b0;
            state_q    <= usb_xact_pkg::DONE;
          end
        end
        default: begin
          state_q <= usb_xact_pkg::IDLE;
        end
      endcase
    end
  end

  // ACK if the sink took the data, NAK if it was dropped
  always_ff @(posedge clock) begin
    if (hsk_go) begin
      hsk_type_q <= out_rx ? `HSK_ACK : `HSK_NAK;
    end
  end

  assign hsk_send_o  = hsk_send_q;
  assign hsk_type_o  = hsk_type_q;
  assign req_ready_o = state_q == usb_xact_pkg::IDLE;
  assign endp_o      = endp_q;

  // Parity moves on an ACK in either direction
  assign flip_o = (state_q == usb_xact_pkg::DATI_ACK && hsk_recv_i && hsk_type_i == `HSK_ACK)
               || (state_q == usb_xact_pkg::DATO_HSK && hsk_sent_i && hsk_type_q == `HSK_ACK);

endmodule

// File: logic/usb_transactor.sv
`timescale 1ns/1ns
`include "usb_xact_config.svh"

module usb_transactor (
  input  logic                    clock,
  input  logic                    reset,
  input  logic [`USB_ADDR_W-1:0]  usb_addr_i,
  output usb_xact_pkg::err_code_e err_code_o,
  // Token and handshake side of the packet decoder and encoder
  input  logic                    tok_recv_i,
  input  usb_xact_pkg::token_t    tok_i,
  input  logic                    hsk_recv_i,
  input  logic [1:0]              hsk_type_i,
  output logic                    hsk_send_o,
  output logic [1:0]              hsk_type_o,
  input  logic                    hsk_sent_i,
  input  logic                    usb_recv_i,
  input  logic                    usb_sent_i,
  // Bulk endpoint levels
  input  logic                    blk_in_ready_i,
  input  logic                    blk_out_ready_i,
  // OUT data from the decoder
  input  usb_xact_pkg::beat_t     usb_rx_i,
  input  logic                    usb_rx_valid_i,
  output logic                    usb_rx_ready_o,
  // OUT data to the bulk sink
  output usb_xact_pkg::beat_t     blk_rx_o,
  output logic                    blk_rx_valid_o,
  input  logic                    blk_rx_ready_i,
  // IN data from the bulk source
  input  usb_xact_pkg::beat_t     blk_tx_i,
  input  logic                    blk_tx_valid_i,
  output logic                    blk_tx_ready_o,
  // IN data to the encoder
  output usb_xact_pkg::beat_t     usb_tx_o,
  output logic                    usb_tx_valid_o,
  input  logic                    usb_tx_ready_i,
  output logic [1:0]              usb_tuser_o
);

  // Token stage to transfer FSM
  logic                    req_valid;
  logic                    req_ready;
  usb_xact_pkg::bulk_req_t req;

  // FSM to parity bits
  logic [`USB_ENDP_W-1:0]  endp;
  logic                    flip;
  logic                    odd;

  // FSM to the two skid registers
  usb_xact_pkg::beat_t     tx_beat;
  logic                    tx_valid;
  logic                    tx_ready;
  usb_xact_pkg::beat_t     rx_beat;
  logic                    rx_valid;
  logic                    rx_ready;

  token_decoder u_token (
    .clock       (clock),
    .reset       (reset),
    .usb_addr_i  (usb_addr_i),
    .tok_recv_i  (tok_recv_i),
    .tok_i       (tok_i),
    .req_ready_i (req_ready),
    .req_valid_o (req_valid),
    .req_o       (req),
    .err_code_o  (err_code_o)
  );

  bulk_xfer_fsm u_bulk (
    .clock           (clock),
    .reset           (reset),
    .req_valid_i     (req_valid),
    .req_i           (req),
    .req_ready_o     (req_ready),
    .blk_in_ready_i  (blk_in_ready_i),
    .blk_out_ready_i (blk_out_ready_i),
    .usb_recv_i      (usb_recv_i),
    .usb_sent_i      (usb_sent_i),
    .hsk_recv_i      (hsk_recv_i),
    .hsk_type_i      (hsk_type_i),
    .hsk_sent_i      (hsk_sent_i),
    .hsk_send_o      (hsk_send_o),
    .hsk_type_o      (hsk_type_o),
    .odd_i           (odd),
    .endp_o          (endp),
    .flip_o          (flip),
    .blk_tx_i        (blk_tx_i),
    .blk_tx_valid_i  (blk_tx_valid_i),
    .blk_tx_ready_o  (blk_tx_ready_o),
    .tx_o            (tx_beat),
    .tx_valid_o      (tx_valid),
    .tx_ready_i      (tx_ready),
    .usb_tuser_o     (usb_tuser_o),
    .usb_rx_i        (usb_rx_i),
    .usb_rx_valid_i  (usb_rx_valid_i),
    .usb_rx_ready_o  (usb_rx_ready_o),
    .rx_o            (rx_beat),
    .rx_valid_o      (rx_valid),
    .rx_ready_i      (rx_ready)
  );

  data_toggle u_toggle (
    .clock  (clock),
    .reset  (reset),
    .endp_i (endp),
    .flip_i (flip),
    .odd_o  (odd)
  );

  // IN beats towards the encoder
  axis_skid #(
    .payload_t (usb_xact_pkg::beat_t)
  ) u_tx_skid (
    .clock     (clock),
    .reset     (reset),
    .s_valid_i (tx_valid),
    .s_data_i  (tx_beat),
    .s_ready_o (tx_ready),
    .m_valid_o (usb_tx_valid_o),
    .m_data_o  (usb_tx_o),
    .m_ready_i (usb_tx_ready_i)
  );

  // OUT beats towards the bulk sink
  axis_skid #(
    .payload_t (usb_xact_pkg::beat_t)
  ) u_rx_skid (
    .clock     (clock),
    .reset     (reset),
    .s_valid_i (rx_valid),
    .s_data_i  (rx_beat),
    .s_ready_o (rx_ready),
    .m_valid_o (blk_rx_valid_o),
    .m_data_o  (blk_rx_o),
    .m_ready_i (blk_rx_ready_i)
  );

endmodule

// File: tb/tb_usb_transactor.sv
`timescale 1ns/1ns
`include "usb_xact_config.svh"

module tb_usb_transactor;

  localparam int NUM_TXN = 28;
  // Trace columns per transaction
  localparam int COLS = 9;
  localparam logic [`USB_ADDR_W-1:0] DEV_ADDR = 7'h2a;
  localparam logic [`USB_ENDP_W-1:0] BULK_EP = `BULK_ENDP;

  logic                    clock;
  logic                    reset;
  logic [`USB_ADDR_W-1:0]  usb_addr_i;
  usb_xact_pkg::err_code_e err_code_o;
  logic                    tok_recv_i;
  usb_xact_pkg::token_t    tok_i;
  logic                    hsk_recv_i;
  logic [1:0]              hsk_type_i;
  logic                    hsk_send_o;
  logic [1:0]              hsk_type_o;
  logic                    hsk_sent_i;
  logic                    usb_recv_i;
  logic                    usb_sent_i;
  logic                    blk_in_ready_i;
  logic                    blk_out_ready_i;
  usb_xact_pkg::beat_t     usb_rx_i;
  logic                    usb_rx_valid_i;
  logic                    usb_rx_ready_o;
  usb_xact_pkg::beat_t     blk_rx_o;
  logic                    blk_rx_valid_o;
  logic                    blk_rx_ready_i;
  usb_xact_pkg::beat_t     blk_tx_i;
  logic                    blk_tx_valid_i;
  logic                    blk_tx_ready_o;
  usb_xact_pkg::beat_t     usb_tx_o;
  logic                    usb_tx_valid_o;
  logic                    usb_tx_ready_i;
  logic [1:0]              usb_tuser_o;

  logic [7:0]               trace_mem [0:NUM_TXN*COLS-1];
  // Host side DATA0/DATA1 model with one bit per endpoint
  logic [`USB_NUM_ENDP-1:0] host_odd;
  logic [31:0]              rng_state;
  logic [1:0]               pid_expect;
  usb_xact_pkg::beat_t      tx_expect [$];
  usb_xact_pkg::beat_t      rx_expect [$];
  usb_xact_pkg::beat_t      tx_want;
  usb_xact_pkg::beat_t      rx_want;
  int txn = 0;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int cycle_limit = 0;

  usb_transactor u_usb_transactor (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Run limit from the total byte count of the trace
  always @(posedge clock) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: run exceeded %0d cycles at row %0d", cycle_limit, txn);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Data byte k of a packet that counts up from first
  function automatic usb_xact_pkg::beat_t data_beat(input logic [7:0] first, input int k,
                                                    input int cnt);
    usb_xact_pkg::beat_t b;
    b.tdata = first + 8'(k);
    b.tkeep = 1'b1;
    b.tlast = (k == cnt - 1);
    return b;
  endfunction

  task automatic compare_value(input string name, input int expected, input int actual);
    checks++;
    assert (expected == actual) else begin
      errors++;
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error: %s", what);
    end
  endtask

  // Step to 1 ns past the next rising edge and draw new sink readies
  task automatic next_cycle();
    @(posedge clock);
    #1;
    rng_state      = xorshift32(rng_state);
    usb_tx_ready_i = rng_state[5];
    blk_rx_ready_i = rng_state[17];
  endtask

  task automatic send_token(input logic [1:0] ttype, input logic [`USB_ADDR_W-1:0] addr,
                            input logic [`USB_ENDP_W-1:0] endp);
    tok_i.ttype = ttype;
    tok_i.addr  = addr;
    tok_i.endp  = endp;
    tok_recv_i  = 1'b1;
    next_cycle();
    tok_recv_i  = 1'b0;
  endtask

  // Encoder side of the IN stream where a beat moves at the next rising edge
  always @(negedge clock) begin
    if (!reset && usb_tx_valid_o && usb_tx_ready_i) begin
      if (tx_expect.size() == 0) begin
        expect_true(1'b0, $sformatf("row %0d: beat on usb_tx when none was expected", txn));
      end else begin
        tx_want = tx_expect.pop_front();
        compare_value($sformatf("row %0d usb_tx tkeep", txn),
                      int'(tx_want.tkeep), int'(usb_tx_o.tkeep));
        compare_value($sformatf("row %0d usb_tx tlast", txn),
                      int'(tx_want.tlast), int'(usb_tx_o.tlast));
        // ZDP carries no byte
        if (tx_want.tkeep) begin
          compare_value($sformatf("row %0d usb_tx tdata", txn),
                        int'(tx_want.tdata), int'(usb_tx_o.tdata));
        end
        compare_value($sformatf("row %0d data pid", txn), int'(pid_expect), int'(usb_tuser_o));
      end
    end
  end

  // Bulk sink side of the OUT stream
  always @(negedge clock) begin
    if (!reset && blk_rx_valid_o && blk_rx_ready_i) begin
      if (rx_expect.size() == 0) begin
        expect_true(1'b0, $sformatf("row %0d: beat on blk_rx when none was expected", txn));
      end else begin
        rx_want = rx_expect.pop_front();
        compare_value($sformatf("row %0d blk_rx tdata", txn),
                      int'(rx_want.tdata), int'(blk_rx_o.tdata));
        compare_value($sformatf("row %0d blk_rx tkeep", txn),
                      int'(rx_want.tkeep), int'(blk_rx_o.tkeep));
        compare_value($sformatf("row %0d blk_rx tlast", txn),
                      int'(rx_want.tlast), int'(blk_rx_o.tlast));
      end
    end
  end

  task automatic run_bulk_in(input logic rdy, input int cnt, input logic [7:0] first,
                             input logic [1:0] pid_trace);
    int sent;
    int k;
    usb_xact_pkg::beat_t zdp;
    sent = 0;
    zdp.tlast = 1'b1;
    zdp.tkeep = 1'b0;
    zdp.tdata = '0;
    pid_expect = host_odd[`BULK_ENDP] ? `DATA1 : `DATA0;
    compare_value($sformatf("row %0d trace data pid", txn), int'(pid_trace), int'(pid_expect));
    // Source not ready means one zero-data packet
    if (rdy) begin
      for (k = 0; k < cnt; k++) begin
        tx_expect.push_back(data_beat(first, k, cnt));
      end
    end else begin
      tx_expect.push_back(zdp);
    end
    blk_in_ready_i = rdy;
    blk_tx_valid_i = rdy && (cnt > 0);
    blk_tx_i       = data_beat(first, 0, cnt);
    send_token(`PID_IN, DEV_ADDR, BULK_EP);
    while (tx_expect.size() != 0) begin
      @(negedge clock);
      if (blk_tx_valid_i && blk_tx_ready_o) begin
        sent++;
      end
      next_cycle();
      blk_tx_valid_i = rdy && (sent < cnt);
      blk_tx_i       = data_beat(first, sent, cnt);
    end
    blk_tx_valid_i = 1'b0;
    // Packet is on the wire and then the host ACKs it
    usb_sent_i = 1'b1;
    next_cycle();
    usb_sent_i = 1'b0;
    hsk_recv_i = 1'b1;
    hsk_type_i = `HSK_ACK;
    next_cycle();
    hsk_recv_i = 1'b0;
    host_odd[`BULK_ENDP] = ~host_odd[`BULK_ENDP];
  endtask

  task automatic run_bulk_out(input logic rdy, input int cnt, input logic [7:0] first,
                              input logic [1:0] hsk_trace);
    int sent;
    int k;
    int since_recv;
    sent = 0;
    // Only a ready sink receives the bytes
    if (rdy) begin
      for (k = 0; k < cnt; k++) begin
        rx_expect.push_back(data_beat(first, k, cnt));
      end
    end
    blk_out_ready_i = rdy;
    usb_rx_valid_i  = cnt > 0;
    usb_rx_i        = data_beat(first, 0, cnt);
    send_token(`PID_OUT, DEV_ADDR, BULK_EP);
    while (sent < cnt) begin
      @(negedge clock);
      if (usb_rx_valid_i && usb_rx_ready_o) begin
        sent++;
      end
      next_cycle();
      usb_rx_valid_i = sent < cnt;
      usb_rx_i       = data_beat(first, sent, cnt);
    end
    // End of the data packet starts the count up to the handshake
    usb_recv_i = 1'b1;
    @(negedge clock);
    since_recv = 0;
    while (!hsk_send_o) begin
      next_cycle();
      usb_recv_i = 1'b0;
      @(negedge clock);
      since_recv++;
    end
    compare_value($sformatf("row %0d handshake delay", txn), `EOP_DELAY + 1, since_recv);
    compare_value($sformatf("row %0d handshake type", txn), int'(hsk_trace), int'(hsk_type_o));
    next_cycle();
    hsk_sent_i = 1'b1;
    next_cycle();
    hsk_sent_i = 1'b0;
    if (rdy) begin
      host_odd[`BULK_ENDP] = ~host_odd[`BULK_ENDP];
    end
    while (rx_expect.size() != 0) begin
      next_cycle();
    end
  endtask

  // Nothing may answer an ignored or rejected token
  task automatic run_other(input logic [1:0] ttype, input logic [`USB_ADDR_W-1:0] addr,
                           input logic [`USB_ENDP_W-1:0] endp);
    send_token(ttype, addr, endp);
    repeat (4) begin
      @(negedge clock);
      expect_true(!hsk_send_o, $sformatf("row %0d: handshake sent for a rejected token", txn));
      expect_true(!usb_tx_valid_o && !blk_rx_valid_o,
                  $sformatf("row %0d: stream output for a rejected token", txn));
      next_cycle();
    end
  endtask

  initial begin
    int base;
    int r;
    logic [1:0] ttype;
    logic [`USB_ADDR_W-1:0] addr;
    logic [`USB_ENDP_W-1:0] endp;
    logic bulk;
    reset           = 1'b1;
    usb_addr_i      = DEV_ADDR;
    tok_recv_i      = 1'b0;
    tok_i           = '0;
    hsk_recv_i      = 1'b0;
    hsk_type_i      = `HSK_ACK;
    hsk_sent_i      = 1'b0;
    usb_recv_i      = 1'b0;
    usb_sent_i      = 1'b0;
    blk_in_ready_i  = 1'b0;
    blk_out_ready_i = 1'b0;
    usb_rx_i        = '0;
    usb_rx_valid_i  = 1'b0;
    blk_rx_ready_i  = 1'b0;
    blk_tx_i        = '0;
    blk_tx_valid_i  = 1'b0;
    usb_tx_ready_i  = 1'b0;
    host_odd        = '0;
    pid_expect      = `DATA0;
    rng_state       = 32'd8359;
    $readmemh("tb/usb_trace.txt", trace_mem);
    cycle_limit = 200;
    for (r = 0; r < NUM_TXN; r++) begin
      cycle_limit += 20 * int'(trace_mem[r*COLS+4]);
    end
    repeat (10) next_cycle();
    reset = 1'b0;
    for (txn = 0; txn < NUM_TXN; txn++) begin
      base  = txn * COLS;
      ttype = trace_mem[base][1:0];
      addr  = trace_mem[base+1][`USB_ADDR_W-1:0];
      endp  = trace_mem[base+2][`USB_ENDP_W-1:0];
      bulk  = (addr == DEV_ADDR) && (endp == BULK_EP)
           && (ttype == `PID_IN || ttype == `PID_OUT);
      if (bulk && ttype == `PID_IN) begin
        run_bulk_in(trace_mem[base+3][0], int'(trace_mem[base+4]), trace_mem[base+5],
                    trace_mem[base+7][1:0]);
      end else if (bulk) begin
        run_bulk_out(trace_mem[base+3][0], int'(trace_mem[base+4]), trace_mem[base+5],
                     trace_mem[base+8][1:0]);
      end else begin
        run_other(ttype, addr, endp);
      end
      @(negedge clock);
      compare_value($sformatf("row %0d err_code", txn),
                    int'(trace_mem[base+6]), int'(err_code_o));
      next_cycle();
    end
    // Late beats still reach the monitors
    repeat (4) next_cycle();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: tb/usb_trace.txt
// type addr endp rdy count first | exp_err exp_pid exp_hsk, all hex
// type 0 OUT 1 SOF 2 IN 3 SETUP, err 0 NONE 1 BLKI 2 BLKO 3 TOKN, ff means no such packet
01 2a 00 01 00 00  00 ff ff
02 2a 01 01 04 10  00 00 ff
02 2a 01 01 03 a0  00 02 ff
00 2a 01 01 05 30  00 ff 00
02 2a 01 00 00 00  00 02 ff
03 2a 00 01 00 00  03 ff ff
02 15 01 01 00 00  03 ff ff
00 2a 01 00 04 50  00 ff 02
02 2a 01 01 02 60  00 00 ff
02 2a 02 01 00 00  01 ff ff
00 2a 03 01 00 00  02 ff ff
01 2a 00 01 00 00  02 ff ff
00 2a 01 01 08 70  00 ff 00
02 2a 01 01 10 80  00 00 ff
00 33 01 01 00 00  00 ff ff
00 2a 01 00 01 90  00 ff 02
00 2a 01 01 01 91  00 ff 00
02 2a 01 00 00 00  00 00 ff
02 2a 00 01 00 00  01 ff ff
02 2a 01 01 0c c0  00 02 ff
03 2a 01 01 00 00  03 ff ff
00 2a 01 01 0a e0  00 ff 00
02 2a 01 01 01 f5  00 02 ff
00 2a 00 01 00 00  02 ff ff
02 2a 01 01 06 01  00 00 ff
00 2a 01 01 02 40  00 ff 00
02 2a 01 01 03 20  00 00 ff
01 00 00 01 00 00  00 ff ff

// File: vlog.f
+incdir+logic
logic/usb_xact_pkg.sv
logic/token_decoder.sv
logic/data_toggle.sv
logic/axis_skid.sv
logic/bulk_xfer_fsm.sv
logic/usb_transactor.sv
tb/tb_usb_transactor.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the transactor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_usb_transactor \
  -Mdir obj_dir -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
